/* source/prom_pkg.sv */
// Serial flash controller package: flash opcodes, serial bit counts and the host command word
package prom_pkg;

    // M25P16 opcodes carried in the top byte of a command
    localparam logic [7:0] OP_NONE         = 8'h00;  // empty slot, never sent
    localparam logic [7:0] OP_READ         = 8'h03;  // read data, 4 bytes
    localparam logic [7:0] OP_STATUS       = 8'h05;  // read status register
    localparam logic [7:0] OP_READ_ID      = 8'h9F;  // jedec id, 3 bytes
    localparam logic [7:0] OP_SECTOR_ERASE = 8'hD8;  // erase one 64 KB sector

    // serial bit count, 0 to 32
    typedef logic [5:0] bit_count_t;

    // one command word, either as opcode over address or as a plain word
    typedef union packed {
        struct packed {
            logic [7:0]  opcode;  // flash instruction byte
            logic [23:0] addr;    // byte address, msb first on the wire
        } fields;
        logic [31:0] raw;         // whole word, zero means no command
    } prom_word_u;

endpackage

/* source/prom_cmd_reg.sv */
// Flash command register: holds one host command until the SPI engine retires it
`timescale 1ns/100ps

module prom_cmd_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_write,       // host write strobe, one clock
    input  prom_pkg::prom_word_u cmd_word,        // host command word
    input  logic                 prom_cmd_clear,  // retire request from engine, level
    output prom_pkg::prom_word_u prom_cmd,        // held command, zero when empty
    output logic                 cmd_busy         // slot occupied
);

    logic cmd_accept;  // write lands in an empty slot

    // zero words are dropped so empty never looks busy
    assign cmd_accept = cmd_write && !cmd_busy && (cmd_word.raw != 32'd0);

    always_ff @(posedge clk) begin
        if (!reset) begin
            prom_cmd <= '0;                          // slot empty
            cmd_busy <= 1'b0;
        end else if (cmd_accept) begin
            prom_cmd <= cmd_word;                    // latch host command
            cmd_busy <= 1'b1;
        end else if (prom_cmd_clear && cmd_busy) begin
            prom_cmd <= '0;                          // first clock of clear empties slot
            cmd_busy <= 1'b0;                        // host may write again next clock
        end
    end

    // a pending command always shows as busy to the host
    a_busy_covers_cmd: assert property (
        @(posedge clk) disable iff (!reset)
        (prom_cmd.raw != 32'd0) |-> cmd_busy
    );

endmodule

/* source/prom_spi_engine.sv */
// SPI engine: runs chip select, serial send and serial receive for one flash command
`timescale 1ns/100ps

module prom_spi_engine (
    input  logic                 clk,
    input  logic                 reset,
    input  prom_pkg::prom_word_u prom_cmd,        // command from register, zero when empty
    input  logic                 result_full,     // queue has no room
    input  logic                 prom_miso,       // serial in from flash
    output logic                 prom_cmd_clear,  // retire request, held until cmd reads zero
    output logic                 result_push,     // one clock per command
    output logic [31:0]          result_word,     // received bits, right aligned
    output logic                 result_bad,      // unknown opcode
    output logic                 prom_mosi,       // serial out to flash
    output logic                 prom_sclk,       // serial clock, half the system rate
    output logic                 prom_cs          // chip select, active low
);

    import prom_pkg::*;

    localparam logic [2:0] ST_IDLE          = 3'd0;
    localparam logic [2:0] ST_CHIP_SELECT   = 3'd1;
    localparam logic [2:0] ST_WRITE         = 3'd2;
    localparam logic [2:0] ST_READ          = 3'd3;
    localparam logic [2:0] ST_CHIP_DESELECT = 3'd4;
    localparam logic [2:0] ST_WAIT_CLEAR    = 3'd5;

    logic [2:0]  state;
    logic [6:0]  seqn;       // phase counter, bit 0 is sclk
    bit_count_t  send_bits;  // bits to shift out
    bit_count_t  recv_bits;  // bits to shift in
    logic [31:0] tx_data;    // outgoing shift register, msb on the pin
    logic        op_known;   // opcode is one the flash is sent
    bit_count_t  op_send;
    bit_count_t  op_recv;

    assign prom_sclk = seqn[0];
    assign prom_mosi = tx_data[31];

    // opcode decode into transfer lengths
    always_comb begin
        op_known = 1'b1;
        op_send  = 6'd0;
        op_recv  = 6'd0;
        case (prom_cmd.fields.opcode)
            OP_READ: begin
                op_send = 6'd32;  // opcode plus 24-bit address
                op_recv = 6'd32;  // four data bytes
            end
            OP_STATUS: begin
                op_send = 6'd8;
                op_recv = 6'd8;
            end
            OP_READ_ID: begin
                op_send = 6'd8;
                op_recv = 6'd24;  // manufacturer, type, capacity
            end
            OP_SECTOR_ERASE: begin
                op_send = 6'd32;
                op_recv = 6'd0;   // nothing comes back
            end
            OP_NONE: op_known = 1'b0;  // address with no opcode is not a flash command
            default: op_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state          <= ST_IDLE;
            seqn           <= '0;
            send_bits      <= '0;
            recv_bits      <= '0;
            tx_data        <= '0;
            result_word    <= '0;
            result_bad     <= 1'b0;
            result_push    <= 1'b0;
            prom_cmd_clear <= 1'b0;
            prom_cs        <= 1'b1;  // deselected
        end else begin
            result_push <= 1'b0;  // strobe by default low
            case (state)
                ST_IDLE: begin
                    // wait for a command and room for its result
                    if (prom_cmd.raw != 32'd0 && !result_full) begin
                        if (op_known) begin
                            send_bits <= op_send;
                            recv_bits <= op_recv;
                            tx_data   <= prom_cmd.raw;  // opcode goes out first
                            state     <= ST_CHIP_SELECT;
                        end else begin
                            result_word    <= '0;    // error result, flash untouched
                            result_bad     <= 1'b1;
                            result_push    <= 1'b1;
                            prom_cmd_clear <= 1'b1;
                            state          <= ST_WAIT_CLEAR;
                        end
                    end
                end

                ST_CHIP_SELECT: begin
                    prom_cs     <= 1'b0;
                    result_word <= '0;    // short replies end up in the low bits
                    result_bad  <= 1'b0;
                    state       <= ST_WRITE;
                end

                ST_WRITE: begin
                    seqn <= seqn + 7'd1;
                    if (prom_sclk) begin
                        tx_data <= tx_data << 1;  // next bit on falling sclk
                    end
                    if (seqn[6:1] == send_bits) begin
                        seqn <= '0;               // sclk back low
                        if (recv_bits == 6'd0) begin
                            prom_cs <= 1'b1;      // erase has no data phase
                            state   <= ST_CHIP_DESELECT;
                        end else begin
                            state <= ST_READ;
                        end
                    end
                end

                ST_READ: begin
                    seqn <= seqn + 7'd1;
                    if (seqn[6:1] == recv_bits) begin
                        seqn    <= '0;
                        prom_cs <= 1'b1;
                        state   <= ST_CHIP_DESELECT;
                    end else if (!prom_sclk) begin
                        result_word <= {result_word[30:0], prom_miso};  // taken as sclk rises
                    end
                end

                ST_CHIP_DESELECT: begin
                    tx_data        <= '0;    // mosi idles low
                    result_push    <= 1'b1;
                    prom_cmd_clear <= 1'b1;
                    state          <= ST_WAIT_CLEAR;
                end

                ST_WAIT_CLEAR: begin
                    // hold clear until the register has emptied
                    if (prom_cmd.raw == 32'd0) begin
                        prom_cmd_clear <= 1'b0;
                        state          <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // flash is selected exactly across the serial phases
    a_cs_in_transfer: assert property (
        @(posedge clk) disable iff (!reset)
        !prom_cs == (state == ST_WRITE || state == ST_READ)
    );

    // room was checked before leaving idle, so a push always fits
    a_push_has_room: assert property (
        @(posedge clk) disable iff (!reset)
        result_push |-> !result_full
    );

endmodule

/* source/prom_result_buf.sv */
// Result queue: circular buffer of flash result words and error flags, popped by the host
`timescale 1ns/100ps

module prom_result_buf #(
    parameter int RESULT_DEPTH = 4  // entries, 2 or more
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        result_push,   // write strobe from engine
    input  logic [31:0] result_word,
    input  logic        result_bad,
    input  logic        result_read,   // host pop strobe
    output logic        result_full,
    output logic        result_valid,  // head entry present
    output logic [31:0] result_data,   // head word
    output logic        result_error   // head error flag
);

    localparam int PTR_W = $clog2(RESULT_DEPTH);
    localparam int CNT_W = $clog2(RESULT_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(RESULT_DEPTH - 1);  // wrap point
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(RESULT_DEPTH);

    logic [31:0]      data_mem [RESULT_DEPTH];  // result words
    logic             bad_mem  [RESULT_DEPTH];  // error flag per entry
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                    // occupied entries
    logic             do_push;
    logic             do_pop;

    assign result_full  = (count == FULL_CNT);
    assign result_valid = (count != '0);
    assign result_data  = data_mem[rd_ptr];     // head shows one clock after push
    assign result_error = bad_mem[rd_ptr];

    assign do_push = result_push && !result_full;
    assign do_pop  = result_read && result_valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            data_mem[wr_ptr] <= result_word;
            bad_mem[wr_ptr]  <= result_bad;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;  // queue empty
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;  // both or neither
            endcase
        end
    end

    // engine must never overrun the queue
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!reset)
        result_push |-> !result_full
    );

    // host pops only a valid head
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!reset)
        result_read |-> result_valid
    );

endmodule

/* source/prom_ctrl_top.sv */
// Serial flash controller top: command register, SPI engine and result queue
`timescale 1ns/100ps

module prom_ctrl_top #(
    parameter int RESULT_DEPTH = 4  // result queue entries
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_write,     // host command strobe
    input  prom_pkg::prom_word_u cmd_word,      // opcode plus address
    input  logic                 result_read,   // host pop strobe
    input  logic                 prom_miso,
    output logic                 cmd_busy,      // command slot occupied
    output logic                 result_valid,
    output logic [31:0]          result_data,
    output logic                 result_error,
    output logic                 prom_mosi,
    output logic                 prom_sclk,
    output logic                 prom_cs
);

    import prom_pkg::*;

    prom_word_u  prom_cmd;        // held command
    logic        prom_cmd_clear;  // engine retire level
    logic        result_push;
    logic [31:0] result_word;
    logic        result_bad;
    logic        result_full;     // back-pressure into engine

    prom_cmd_reg cmd_reg0 (
        .clk            (clk),
        .reset          (reset),
        .cmd_write      (cmd_write),
        .cmd_word       (cmd_word),
        .prom_cmd_clear (prom_cmd_clear),
        .prom_cmd       (prom_cmd),
        .cmd_busy       (cmd_busy)
    );

    prom_spi_engine engine0 (
        .clk            (clk),
        .reset          (reset),
        .prom_cmd       (prom_cmd),
        .result_full    (result_full),
        .prom_miso      (prom_miso),
        .prom_cmd_clear (prom_cmd_clear),
        .result_push    (result_push),
        .result_word    (result_word),
        .result_bad     (result_bad),
        .prom_mosi      (prom_mosi),
        .prom_sclk      (prom_sclk),
        .prom_cs        (prom_cs)
    );

    prom_result_buf #(
        .RESULT_DEPTH (RESULT_DEPTH)
    ) result_buf0 (
        .clk          (clk),
        .reset        (reset),
        .result_push  (result_push),
        .result_word  (result_word),
        .result_bad   (result_bad),
        .result_read  (result_read),
        .result_full  (result_full),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_error (result_error)
    );

endmodule

/* bench/spi_flash_model.sv */
// Serial flash model: answers read, status, id and sector erase from a computed byte pattern
`timescale 1ns/100ps

module spi_flash_model (
    input  logic prom_cs,    // active low select
    input  logic prom_sclk,
    input  logic prom_mosi,
    output logic prom_miso
);

    import prom_pkg::*;

    logic        erased [256];  // one flag per 64 KB sector
    logic [7:0]  erase_count;   // status register contents
    logic [31:0] rx_bits;       // bits taken from mosi
    int          rx_count;
    logic [7:0]  opcode;        // first byte of the transfer
    logic [31:0] reply;         // outgoing bits, msb on the pin
    logic        replying;

    // byte at one address, FF inside an erased sector
    function automatic logic [7:0] mem_byte(input logic [23:0] a);
        if (erased[a[23:16]]) begin
            return 8'hFF;
        end
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            erased[i] = 1'b0;
        end
        erase_count = 8'd0;
        rx_bits     = 32'd0;
        rx_count    = 0;
        opcode      = 8'd0;
        reply       = 32'd0;
        replying    = 1'b0;
        prom_miso   = 1'b0;
    end

    always @(negedge prom_cs) begin
        rx_count  = 0;     // new transfer
        replying  = 1'b0;
        reply     = 32'd0;
        prom_miso = 1'b0;
    end

    always @(posedge prom_sclk) begin
        if (!prom_cs) begin
            rx_bits  = {rx_bits[30:0], prom_mosi};  // msb first
            rx_count = rx_count + 1;
            if (rx_count == 8) begin
                opcode = rx_bits[7:0];
            end
        end
    end

    always @(negedge prom_sclk) begin
        if (!prom_cs) begin
            if (replying) begin
                reply = reply << 1;                  // next reply bit
            end else if (rx_count == 8 && opcode == OP_STATUS) begin
                reply    = {erase_count, 24'h0};
                replying = 1'b1;
            end else if (rx_count == 8 && opcode == OP_READ_ID) begin
                reply    = {24'h202015, 8'h00};
                replying = 1'b1;
            end else if (rx_count == 32 && opcode == OP_READ) begin
                reply = {mem_byte(rx_bits[23:0]), mem_byte(rx_bits[23:0] + 24'd1),
                         mem_byte(rx_bits[23:0] + 24'd2), mem_byte(rx_bits[23:0] + 24'd3)};
                replying = 1'b1;
            end
            prom_miso = reply[31];
        end
    end

    // erase takes effect when the select is released
    always @(posedge prom_cs) begin
        if (rx_count == 32 && opcode == OP_SECTOR_ERASE) begin
            erased[rx_bits[23:16]] = 1'b1;
            erase_count            = erase_count + 8'd1;  // wraps at 256
        end
    end

endmodule

/* bench/prom_ctrl_tb.sv */
// Flash controller testbench that runs a table of commands against a flash model
`timescale 1ns/100ps

module prom_ctrl_tb;

    import prom_pkg::*;

    localparam int RESULT_DEPTH   = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int TABLE_TESTS    = 12;                 // single command tests
    localparam int QUEUED_TESTS   = RESULT_DEPTH + 1;   // back-pressure commands
    localparam int TOTAL_TESTS    = TABLE_TESTS + QUEUED_TESTS + 3;  // plus reset, hold, empty
    localparam int TIMEOUT_CYCLES = TOTAL_TESTS * 160 + RESET_CYCLES;
    localparam int MAX_TESTS      = 32;

    logic        clk;
    logic        reset;
    logic        cmd_write;
    prom_word_u  cmd_word;
    logic        result_read;
    logic        prom_miso;
    logic        cmd_busy;
    logic        result_valid;
    logic [31:0] result_data;
    logic        result_error;
    logic        prom_mosi;
    logic        prom_sclk;
    logic        prom_cs;

    string       test_name [MAX_TESTS];
    prom_word_u  test_cmd  [MAX_TESTS];
    logic [31:0] test_exp  [MAX_TESTS];
    logic        test_bad  [MAX_TESTS];
    int          n_tests;
    int          test_count;
    int          error_count;
    int          cycle_count;
    logic [31:0] lcg_state;
    logic        shadow_erased [256];  // sectors erased by earlier table rows
    logic [7:0]  shadow_erases;

    prom_ctrl_top #(
        .RESULT_DEPTH (RESULT_DEPTH)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .cmd_write    (cmd_write),
        .cmd_word     (cmd_word),
        .result_read  (result_read),
        .prom_miso    (prom_miso),
        .cmd_busy     (cmd_busy),
        .result_valid (result_valid),
        .result_data  (result_data),
        .result_error (result_error),
        .prom_mosi    (prom_mosi),
        .prom_sclk    (prom_sclk),
        .prom_cs      (prom_cs)
    );

    spi_flash_model flash0 (
        .prom_cs   (prom_cs),
        .prom_sclk (prom_sclk),
        .prom_mosi (prom_mosi),
        .prom_miso (prom_miso)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [7:0] expected_byte(input logic [23:0] a);
        if (shadow_erased[a[23:16]]) begin
            return 8'hFF;
        end
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    // lowest address lands in the top byte
    function automatic logic [31:0] expected_read(input logic [23:0] a);
        return {expected_byte(a), expected_byte(a + 24'd1),
                expected_byte(a + 24'd2), expected_byte(a + 24'd3)};
    endfunction

    task automatic add_test(input string name, input logic [7:0] op, input logic [23:0] addr,
                            input logic [31:0] exp, input logic bad);
        prom_word_u cmd;
        cmd.fields.opcode    = op;
        cmd.fields.addr      = addr;
        test_name[n_tests]   = name;
        test_cmd[n_tests]    = cmd;
        test_exp[n_tests]    = exp;
        test_bad[n_tests]    = bad;
        n_tests              = n_tests + 1;
    endtask

    task automatic build_table();
        logic [23:0] addr;
        add_test("read_id", OP_READ_ID, 24'h000000, 32'h00202015, 1'b0);
        add_test("status_fresh", OP_STATUS, 24'h000000, {24'h0, shadow_erases}, 1'b0);
        for (int i = 0; i < 4; i++) begin
            lcg_state = lcg_next(lcg_state);
            addr      = lcg_state[31:8];  // address from the upper lcg bits
            add_test($sformatf("read_rand%0d", i), OP_READ, addr, expected_read(addr), 1'b0);
        end
        add_test("erase_3c", OP_SECTOR_ERASE, 24'h3C1234, 32'h0, 1'b0);
        shadow_erased[8'h3C] = 1'b1;
        shadow_erases        = shadow_erases + 8'd1;
        add_test("read_erased", OP_READ, 24'h3C0100, expected_read(24'h3C0100), 1'b0);
        add_test("read_other", OP_READ, 24'h3D0100, expected_read(24'h3D0100), 1'b0);
        add_test("status_after", OP_STATUS, 24'h000000, {24'h0, shadow_erases}, 1'b0);
        add_test("unknown_op", 8'h42, 24'h001000, 32'h0, 1'b1);  // never reaches the flash
        add_test("read_after_bad", OP_READ, 24'h0000FE, expected_read(24'h0000FE), 1'b0);
        // queued without pops so the last one waits on a full queue
        for (int i = 0; i < QUEUED_TESTS; i++) begin
            if (i == 2) begin
                add_test("queued_id", OP_READ_ID, 24'h000000, 32'h00202015, 1'b0);
            end else begin
                lcg_state = lcg_next(lcg_state);
                addr      = lcg_state[31:8];
                add_test($sformatf("queued_read%0d", i), OP_READ, addr,
                         expected_read(addr), 1'b0);
            end
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0b, actual %0b", name, exp, act);
            error_count = error_count + 1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count = test_count + 1;
        if (error_count == errors_before) begin
            $display("ok   %s", name);
        end
    endtask

    // starts and ends on a falling edge
    task automatic send_command(input prom_word_u cmd);
        while (cmd_busy) begin
            @(negedge clk);
        end
        cmd_word  = cmd;
        cmd_write = 1'b1;
        @(negedge clk);
        cmd_write = 1'b0;
        cmd_word  = '0;
    endtask

    task automatic wait_result();
        while (!result_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic pop_result();
        result_read = 1'b1;
        @(negedge clk);
        result_read = 1'b0;  // head moves on at the edge just passed
    endtask

    task automatic check_head(input int idx);
        check_word({test_name[idx], " data"}, test_exp[idx], result_data);
        check_flag({test_name[idx], " error"}, test_bad[idx], result_error);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int errors_before;
        reset         = 1'b0;  // held in reset
        cmd_write     = 1'b0;
        cmd_word      = '0;
        result_read   = 1'b0;
        n_tests       = 0;
        test_count    = 0;
        error_count   = 0;
        lcg_state     = 32'd41481;
        shadow_erases = 8'd0;
        for (int i = 0; i < 256; i++) begin
            shadow_erased[i] = 1'b0;
        end
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        errors_before = error_count;
        check_flag("after_reset prom_cs", 1'b1, prom_cs);
        check_flag("after_reset prom_sclk", 1'b0, prom_sclk);
        check_flag("after_reset prom_mosi", 1'b0, prom_mosi);
        check_flag("after_reset result_valid", 1'b0, result_valid);
        check_flag("after_reset cmd_busy", 1'b0, cmd_busy);
        report_test("after_reset", errors_before);

        // one command at a time with a pop before the next
        for (int i = 0; i < TABLE_TESTS; i++) begin
            errors_before = error_count;
            send_command(test_cmd[i]);
            wait_result();
            check_head(i);
            pop_result();
            report_test(test_name[i], errors_before);
        end

        // fill the queue and hold one more command in the register
        for (int i = TABLE_TESTS; i < n_tests; i++) begin
            send_command(test_cmd[i]);
        end
        errors_before = error_count;
        repeat (160) @(negedge clk);  // longer than one command takes to run
        check_flag("held busy", 1'b1, cmd_busy);
        check_flag("held valid", 1'b1, result_valid);
        report_test("held_when_full", errors_before);

        for (int i = TABLE_TESTS; i < n_tests; i++) begin
            errors_before = error_count;
            wait_result();
            check_head(i);
            pop_result();
            report_test(test_name[i], errors_before);
        end

        errors_before = error_count;
        repeat (160) @(negedge clk);  // a duplicate would show up by now
        check_flag("drained valid", 1'b0, result_valid);
        check_flag("drained busy", 1'b0, cmd_busy);
        report_test("drained_empty", errors_before);

        $display("tests run: %0d, failed checks: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sources.f */
source/prom_pkg.sv
source/prom_cmd_reg.sv
source/prom_spi_engine.sv
source/prom_result_buf.sv
source/prom_ctrl_top.sv
bench/spi_flash_model.sv
bench/prom_ctrl_tb.sv
